/* src/qsnd_bus_pkg.sv */
/* CPU-side bus types and the sound CPU memory map.
   All request strobes are single cycle with no back-pressure. */

package qsnd_bus_pkg;

    localparam int ROM_AW      = 19;     // 512 kB program ROM
    localparam int RAM_AW      = 13;     // 8 kB work RAM
    localparam int BANK_BASE   = 32768;  // banked window starts above the fixed ROM
    localparam int TICK_PERIOD = 32000;  // cen8 ticks per sound interrupt

    localparam logic [15:0] MBOX_ADDR = 16'hd000;  // d000..d002
    localparam logic [15:0] BANK_ADDR = 16'hd003;
    localparam logic [15:0] STAT_ADDR = 16'hd007;

    // sound CPU access, valid for one cycle
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } snd_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] rdata;
    } snd_rsp_t;

    // RAM access, addr is a byte index into the 8 kB RAM
    typedef struct packed {
        logic              valid;
        logic              we;
        logic [RAM_AW-1:0] addr;
        logic [7:0]        wdata;
    } main_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] rdata;
    } main_rsp_t;

    // idx 0 data high, 1 data low, 2 address byte
    typedef struct packed {
        logic       valid;
        logic [1:0] idx;
        logic [7:0] data;
    } mbox_wr_t;

    // where a sound CPU read takes its byte from
    typedef enum logic [1:0] {
        SRC_FF,
        SRC_ROM,
        SRC_RAM,
        SRC_STAT
    } rd_src_t;

endpackage

/* src/qsnd_audio_pkg.sv */
/* DSP-side audio types. Samples are 16-bit signed, two channels
   per frame, and the sample ROM spans up to 8 MB. */

package qsnd_audio_pkg;

    localparam int SAMPLE_W = 16;  // per channel
    localparam int QSND_AW  = 23;  // sample ROM byte address

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] left;
        logic signed [SAMPLE_W-1:0] right;
    } audio_sample_t;

endpackage

/* src/qsnd_addr_decode.sv */
/* Sound CPU decode with a two-stage pipeline. Selects are valid one cycle
   after the request, read data one cycle later. ROM latency is fixed at 1. */
`timescale 1ns/1ns

module qsnd_addr_decode import qsnd_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  snd_req_t          snd_req,
    input  logic [7:0]        rom_data,
    input  logic [7:0]        ram_rdata,
    input  logic              dsp_rdy_n,
    output logic [ROM_AW-1:0] rom_addr,
    output logic              rom_cs,
    output main_req_t         ram_req,
    output mbox_wr_t          mbox_wr,
    output logic              dsp_rst,
    output snd_rsp_t          snd_rsp
);

    logic              rom_hit, ram_hit, mbox_hit, bank_hit, stat_hit;
    rd_src_t           src_nxt;
    logic              ram_v, mbox_v, bank_we, rd1, rd2;
    logic              we1;
    logic [RAM_AW-1:0] ram_addr1;
    logic [1:0]        idx1;
    logic [7:0]        wdata1;
    rd_src_t           src1, src2;
    logic [3:0]        bank;
    logic [7:0]        rdata;

    always_comb begin
        rom_hit  = snd_req.addr[15:14] != 2'b11;  // 0000-bfff
        ram_hit  = snd_req.addr[15:12] == 4'hc || snd_req.addr[15:12] == 4'hf;
        mbox_hit = snd_req.addr[15:2] == MBOX_ADDR[15:2] && snd_req.addr[1:0] != 2'b11;
        bank_hit = snd_req.addr == BANK_ADDR;
        stat_hit = snd_req.addr == STAT_ADDR;
        if (rom_hit)
            src_nxt = SRC_ROM;
        else if (ram_hit)
            src_nxt = SRC_RAM;
        else if (stat_hit)
            src_nxt = SRC_STAT;
        else
            src_nxt = SRC_FF;
    end

    // stage 1 selects and stage 2 read valid, bank register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs  <= 1'b0;
            ram_v   <= 1'b0;
            mbox_v  <= 1'b0;
            bank_we <= 1'b0;
            rd1     <= 1'b0;
            rd2     <= 1'b0;
            bank    <= 4'd0;
            dsp_rst <= 1'b1;  // DSP held until the CPU releases it
        end else begin
            rom_cs  <= snd_req.valid && rom_hit;
            ram_v   <= snd_req.valid && ram_hit;
            mbox_v  <= snd_req.valid && snd_req.we && mbox_hit;
            bank_we <= snd_req.valid && snd_req.we && bank_hit;
            rd1     <= snd_req.valid && !snd_req.we;
            rd2     <= rd1;
            if (bank_we) begin
                bank    <= wdata1[3:0];
                dsp_rst <= ~wdata1[7];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (snd_req.valid) begin
            we1       <= snd_req.we;
            ram_addr1 <= snd_req.addr[RAM_AW-1:0];
            idx1      <= snd_req.addr[1:0];
            wdata1    <= snd_req.wdata;
            src1      <= src_nxt;
        end
        if (snd_req.valid && rom_hit) begin
            // upper half goes through the bank window
            rom_addr <= snd_req.addr[15]
                ? ROM_AW'(BANK_BASE) + ROM_AW'({bank, snd_req.addr[13:0]})
                : ROM_AW'(snd_req.addr[14:0]);
        end
        src2 <= src1;
    end

    always_comb begin
        case (src2)
            SRC_ROM:  rdata = rom_data;
            SRC_RAM:  rdata = ram_rdata;
            SRC_STAT: rdata = {dsp_rdy_n, 3'b111, bank};
            default:  rdata = 8'hff;  // open bus
        endcase
    end

    assign ram_req = '{valid: ram_v, we: we1, addr: ram_addr1, wdata: wdata1};
    assign mbox_wr = '{valid: mbox_v, idx: idx1, data: wdata1};
    assign snd_rsp = '{valid: rd2, rdata: rdata};

endmodule

/* src/qsnd_shared_ram.sv */
/* 8 kB work RAM shared with the main CPU. The main side owns the RAM only
   while main_grant is high; the sound CPU must be stopped by busak then. */
`timescale 1ns/1ns

module qsnd_shared_ram import qsnd_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen8,
    input  main_req_t  snd_ram_req,
    input  logic       main_buse,
    input  logic       busak,
    input  main_req_t  main_req,
    output logic [7:0] ram_rdata,
    output logic       busrq,
    output logic       main_grant,
    output main_rsp_t  main_rsp
);

    logic [1:0] grant_sr;  // two cen8 stages before the main side owns the RAM
    logic [7:0] mem [0:(1 << RAM_AW) - 1];
    logic [7:0] ram_q;
    logic       main_rd_q;
    main_req_t  port;

    assign busrq      = main_buse;  // level request straight to the sound CPU
    assign main_grant = grant_sr[1];
    assign port       = main_grant ? main_req : snd_ram_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant_sr <= 2'b00;
        end else if (!main_buse) begin
            grant_sr <= 2'b00;  // release takes effect right away
        end else if (cen8) begin
            grant_sr <= {grant_sr[0], busrq & busak};
        end
    end

    // single port, one access per cycle
    always_ff @(posedge clk) begin
        if (port.valid) begin
            if (port.we)
                mem[port.addr] <= port.wdata;
            ram_q <= mem[port.addr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            main_rd_q <= 1'b0;
        else
            main_rd_q <= main_grant && main_req.valid && !main_req.we;
    end

    assign ram_rdata = ram_q;
    assign main_rsp  = '{valid: main_rd_q, rdata: ram_q};

    // the sound CPU is parked by the bus lock, so the decoder stays quiet
    a_no_snd_during_grant: assert property (
        @(posedge clk) disable iff (rst)
        snd_ram_req.valid |-> !main_grant
    ) else $error("sound RAM access while main CPU holds the bus");

endmodule

/* src/qsnd_tick_irq.sv */
/* Periodic sound CPU interrupt. The level stays up until int_ack,
   which wins over a wrap in the same cycle. */
`timescale 1ns/1ns

module qsnd_tick_irq import qsnd_bus_pkg::*; #(
    parameter int PERIOD = TICK_PERIOD
) (
    input  logic clk,
    input  logic rst,
    input  logic cen8,
    input  logic int_ack,
    output logic snd_irq
);

    logic [$clog2(PERIOD)-1:0] cnt;
    logic                      wrap;

    assign wrap = cnt == $bits(cnt)'(PERIOD - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            snd_irq <= 1'b0;
        end else begin
            if (cen8)
                cnt <= wrap ? '0 : cnt + 1'b1;
            if (int_ack)
                snd_irq <= 1'b0;  // ack is sampled every clk
            else if (cen8 && wrap)
                snd_irq <= 1'b1;
        end
    end

endmodule

/* src/qsnd_dsp_mailbox.sv */
/* CPU to DSP mailbox. A write to the address byte starts a two-word read
   by the DSP: address byte first, then the data word. */
`timescale 1ns/1ns

module qsnd_dsp_mailbox import qsnd_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  mbox_wr_t    mbox_wr,
    input  logic        dsp_pids,
    input  logic        dsp_iack,
    output logic        dsp_irq,
    output logic        dsp_rdy_n,
    output logic [15:0] dsp_pbus_in
);

    logic [7:0]  addr_byte;
    logic [15:0] data_word;
    logic [1:0]  sel;  // words left to hand over, msb selects the address

    // byte latches
    always_ff @(posedge clk) begin
        if (mbox_wr.valid) begin
            case (mbox_wr.idx)
                2'd0:    data_word[15:8] <= mbox_wr.data;
                2'd1:    data_word[7:0]  <= mbox_wr.data;
                2'd2:    addr_byte       <= mbox_wr.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dsp_irq <= 1'b0;
            sel     <= 2'b00;
        end else if (mbox_wr.valid && mbox_wr.idx == 2'd2) begin
            dsp_irq <= 1'b1;
            sel     <= 2'b11;
        end else if (dsp_pids) begin
            dsp_irq <= 1'b0;  // first read clears it
            sel     <= sel >> 1;
        end
    end

    assign dsp_pbus_in = sel[1] ? {8'd0, addr_byte} : data_word;
    assign dsp_rdy_n   = ~(dsp_irq | dsp_iack);

    // DSP reads only what the CPU queued
    a_pids_with_data: assert property (
        @(posedge clk) disable iff (rst)
        dsp_pids |-> sel != 2'b00
    ) else $error("DSP parallel read with empty mailbox");

endmodule

/* src/qsnd_dsp_out.sv */
/* DSP serial audio and sample ROM address capture. DSP outputs are
   sampled on clk, so ock and the strobes must stay stable for 2+ cycles. */
`timescale 1ns/1ns

module qsnd_dsp_out import qsnd_audio_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               dsp_ock,
    input  logic               dsp_do,
    input  logic               dsp_psel,
    input  logic               dsp_pods_n,
    input  logic [15:0]        dsp_pbus_out,
    input  logic [15:0]        dsp_ab,
    output audio_sample_t      audio,
    output logic               sample,
    output logic [QSND_AW-1:0] qsnd_addr
);

    logic                last_ock, last_psel, last_pods_n;
    logic                ock_fall, ock_rise, psel_rise, pods_rise;
    logic [SAMPLE_W-1:0] left_sr, right_sr;

    assign ock_fall  = last_ock && !dsp_ock;
    assign ock_rise  = !last_ock && dsp_ock;
    assign psel_rise = !last_psel && dsp_psel;
    assign pods_rise = !last_pods_n && dsp_pods_n;

    // msb first, psel picks the channel
    always_ff @(posedge clk) begin
        if (ock_fall) begin
            if (!dsp_psel)
                left_sr <= {left_sr[SAMPLE_W-2:0], dsp_do};
            else
                right_sr <= {right_sr[SAMPLE_W-2:0], dsp_do};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_ock    <= 1'b1;  // high idle avoids a false rise out of reset
            last_psel   <= 1'b1;
            last_pods_n <= 1'b1;
            audio       <= '0;
            sample      <= 1'b0;
            qsnd_addr   <= '0;
        end else begin
            last_ock    <= dsp_ock;
            last_psel   <= dsp_psel;
            last_pods_n <= dsp_pods_n;
            sample      <= psel_rise;
            if (psel_rise)
                audio <= '{left: left_sr, right: right_sr};
            if (pods_rise)
                qsnd_addr[15:0] <= dsp_pbus_out;
            if (ock_rise && dsp_ab[15])
                qsnd_addr[QSND_AW-1:16] <= dsp_ab[QSND_AW-17:0];  // bank bits
        end
    end

endmodule

/* src/qsnd_sound_top.sv */
/* Sound board glue between the sound CPU, main CPU and QSound DSP.
   The CPUs, the DSP and the program ROM sit outside this level. */
`timescale 1ns/1ns

module qsnd_sound_top import qsnd_bus_pkg::*, qsnd_audio_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen8,
    // sound CPU
    input  snd_req_t           snd_req,
    output snd_rsp_t           snd_rsp,
    input  logic               int_ack,
    output logic               snd_irq,
    output logic               busrq,
    input  logic               busak,
    // program ROM
    output logic [ROM_AW-1:0]  rom_addr,
    output logic               rom_cs,
    input  logic [7:0]         rom_data,
    // main CPU
    input  logic               main_buse,
    input  main_req_t          main_req,
    output logic               main_grant,
    output main_rsp_t          main_rsp,
    // QSound DSP
    output logic               dsp_rst,
    output logic               dsp_irq,
    output logic               dsp_rdy_n,
    input  logic               dsp_iack,
    input  logic               dsp_pids,
    output logic [15:0]        dsp_pbus_in,
    input  logic               dsp_ock,
    input  logic               dsp_do,
    input  logic               dsp_psel,
    input  logic               dsp_pods_n,
    input  logic [15:0]        dsp_pbus_out,
    input  logic [15:0]        dsp_ab,
    output audio_sample_t      audio,
    output logic               sample,
    output logic [QSND_AW-1:0] qsnd_addr
);

    main_req_t  snd_ram_req;
    mbox_wr_t   mbox_wr;
    logic [7:0] ram_rdata;

    qsnd_addr_decode qsnd_addr_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .snd_req   (snd_req),
        .rom_data  (rom_data),
        .ram_rdata (ram_rdata),
        .dsp_rdy_n (dsp_rdy_n),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .ram_req   (snd_ram_req),
        .mbox_wr   (mbox_wr),
        .dsp_rst   (dsp_rst),
        .snd_rsp   (snd_rsp)
    );

    qsnd_shared_ram qsnd_shared_ram_inst (
        .clk         (clk),
        .rst         (rst),
        .cen8        (cen8),
        .snd_ram_req (snd_ram_req),
        .main_buse   (main_buse),
        .busak       (busak),
        .main_req    (main_req),
        .ram_rdata   (ram_rdata),
        .busrq       (busrq),
        .main_grant  (main_grant),
        .main_rsp    (main_rsp)
    );

    qsnd_tick_irq qsnd_tick_irq_inst (
        .clk     (clk),
        .rst     (rst),
        .cen8    (cen8),
        .int_ack (int_ack),
        .snd_irq (snd_irq)
    );

    qsnd_dsp_mailbox qsnd_dsp_mailbox_inst (
        .clk         (clk),
        .rst         (rst),
        .mbox_wr     (mbox_wr),
        .dsp_pids    (dsp_pids),
        .dsp_iack    (dsp_iack),
        .dsp_irq     (dsp_irq),
        .dsp_rdy_n   (dsp_rdy_n),
        .dsp_pbus_in (dsp_pbus_in)
    );

    qsnd_dsp_out qsnd_dsp_out_inst (
        .clk          (clk),
        .rst          (rst),
        .dsp_ock      (dsp_ock),
        .dsp_do       (dsp_do),
        .dsp_psel     (dsp_psel),
        .dsp_pods_n   (dsp_pods_n),
        .dsp_pbus_out (dsp_pbus_out),
        .dsp_ab       (dsp_ab),
        .audio        (audio),
        .sample       (sample),
        .qsnd_addr    (qsnd_addr)
    );

endmodule

/* test/tb_qsnd.sv */
/* Testbench for the sound board glue. Models the sound CPU, main CPU, ROM and DSP
   with single-cycle strobes; the tick test alone runs about 130k cycles. */
`timescale 1ns/1ns

module tb_qsnd import qsnd_bus_pkg::*, qsnd_audio_pkg::*;;

    localparam int TIMEOUT = 4 * TICK_PERIOD + 12000;  // two irq periods at half rate

    logic clk = 1'b0, rst = 1'b1, cen8 = 1'b0;
    snd_req_t snd_req;
    snd_rsp_t snd_rsp;
    logic int_ack, snd_irq, busrq, busak, rom_cs, main_buse, main_grant;
    logic [ROM_AW-1:0] rom_addr;
    logic [7:0] rom_data;
    main_req_t main_req;
    main_rsp_t main_rsp;
    logic dsp_rst, dsp_irq, dsp_rdy_n, dsp_iack, dsp_pids, dsp_ock, dsp_do, dsp_psel, dsp_pods_n;
    logic [15:0] dsp_pbus_in, dsp_pbus_out, dsp_ab;
    audio_sample_t audio;
    logic sample;
    logic [QSND_AW-1:0] qsnd_addr;

    logic [31:0] rng = 32'h2bc1;
    logic [7:0]  ram_model [0:(1 << RAM_AW) - 1];
    logic [7:0]  exp_q [$];  // expected read bytes in issue order
    logic [7:0]  exp_b;
    logic [3:0]  exp_bank = 4'd0;
    logic        exp_dsp_irq = 1'b0, exp_dsp_rst = 1'b1;
    int errors = 0, rsp_errors = 0, start_errs = 0, tests = 0, failed = 0, cycles = 0;

    qsnd_sound_top qsnd_sound_top_inst (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        cen8 = ~cen8;  // every other cycle
    end

    // program ROM with one cycle of latency
    always @(posedge clk) begin : rom_model
        logic [ROM_AW-1:0] ra;
        logic cs;
        ra = rom_addr;
        cs = rom_cs;
        #1;
        if (cs)
            rom_data = rom_byte(ra);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout after %0d cycles, test did not finish", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng;
    endfunction

    function automatic logic [7:0] rom_byte(input logic [ROM_AW-1:0] ra);
        return ra[7:0] ^ ra[15:8] ^ {ra[18:16], 5'h0b};
    endfunction

    function automatic logic [ROM_AW-1:0] exp_rom_addr(input logic [15:0] a, input logic [3:0] b);
        if (a[15])
            return ROM_AW'(BANK_BASE + int'(b) * 16384 + int'(a[13:0]));
        return ROM_AW'(a);
    endfunction

    function automatic logic [7:0] exp_read(input logic [15:0] a);
        if (a[15:14] != 2'b11)
            return rom_byte(exp_rom_addr(a, exp_bank));
        if (a[15:12] == 4'hc || a[15:12] == 4'hf)
            return ram_model[a[12:0]];
        if (a == 16'hd007)
            return {~exp_dsp_irq, 3'b111, exp_bank};
        return 8'hff;
    endfunction

    function automatic audio_sample_t exp_frame(input logic [15:0] l, input logic [15:0] r);
        return '{left: l, right: r};
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic hold(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors + rsp_errors == start_errs) begin
            $display("%-10s passed", name);
        end else begin
            failed++;
            $display("%-10s failed with %0d errors", name, errors + rsp_errors - start_errs);
        end
        start_errs = errors + rsp_errors;
    endtask

    // one sound CPU access, selects checked at N+1
    task automatic sound_access(input logic we, input logic [15:0] a, input logic [7:0] d);
        logic [ROM_AW-1:0] ra;
        ra = exp_rom_addr(a, exp_bank);
        @(posedge clk);
        #1;
        snd_req = '{valid: 1'b1, we: we, addr: a, wdata: d};
        if (!we)
            exp_q.push_back(exp_read(a));
        @(posedge clk);
        #1;
        snd_req.valid = 1'b0;
        if (rom_cs !== (a[15:14] != 2'b11))
            report_mismatch("rom_cs", 32'(rom_cs), 32'(a[15:14] != 2'b11));
        if (a[15:14] != 2'b11 && rom_addr !== ra)
            report_mismatch("rom_addr", 32'(rom_addr), 32'(ra));
        if (we && (a[15:12] == 4'hc || a[15:12] == 4'hf))
            ram_model[a[12:0]] = d;
        if (we && a == 16'hd003) begin
            exp_bank    = d[3:0];
            exp_dsp_rst = ~d[7];
        end
        if (we && a == 16'hd002)
            exp_dsp_irq = 1'b1;
    endtask

    task automatic main_access(input logic we, input logic [RAM_AW-1:0] idx, input logic [7:0] d);
        @(posedge clk);
        #1;
        main_req = '{valid: 1'b1, we: we, addr: idx, wdata: d};
        @(posedge clk);
        #1;
        main_req.valid = 1'b0;
        if (!we && main_rsp.valid !== 1'b1)
            report_fault("main CPU read got no response");
        else if (!we && main_rsp.rdata !== ram_model[idx])
            report_mismatch("main_rsp.rdata", 32'(main_rsp.rdata), 32'(ram_model[idx]));
        if (we)
            ram_model[idx] = d;
    endtask

    task automatic drain_reads();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 8) begin
            @(posedge clk);
            n++;
        end
        #1;
        if (exp_q.size() != 0)
            report_fault("read response missing");
        exp_q.delete();
    endtask

    task automatic shift_word(input logic [15:0] w);
        for (int b = 15; b >= 0; b--) begin
            dsp_do  = w[b];
            dsp_ock = 1'b1;
            hold(2);
            dsp_ock = 1'b0;  // falling edge shifts the bit in
            hold(2);
        end
    endtask

    // read responses are compared mid-cycle, where they are stable
    always @(negedge clk) begin
        if (!rst && snd_rsp.valid) begin
            if (exp_q.size() == 0) begin
                rsp_errors++;
                $display("error at %0t: read response without a request", $time);
            end else begin
                exp_b = exp_q.pop_front();
                if (snd_rsp.rdata !== exp_b) begin
                    rsp_errors++;
                    $display("mismatch at %0t: snd_rsp.rdata got %h expected %h",
                             $time, snd_rsp.rdata, exp_b);
                end
            end
        end
    end

    initial begin : stimulus
        logic [15:0] a, l, r, addrs [16];
        logic [7:0]  hi, lo, ad;
        int n, rise1, rise2, ticks;
        snd_req = '0;
        main_req = '0;
        int_ack = 1'b0;
        busak = 1'b0;
        main_buse = 1'b0;
        rom_data = 8'h00;
        dsp_iack = 1'b0;
        dsp_pids = 1'b0;
        dsp_ock = 1'b1;  // idle high, no edge after reset
        dsp_do = 1'b0;
        dsp_psel = 1'b1;
        dsp_pods_n = 1'b1;
        dsp_pbus_out = 16'h0;
        dsp_ab = 16'h0;
        hold(3);
        rst = 1'b0;
        if (rom_cs || snd_rsp.valid || main_grant || snd_irq || dsp_irq || sample || busrq)
            report_fault("control output high after reset");
        if (dsp_rst !== 1'b1 || audio !== '0)
            report_fault("dsp_rst or audio wrong after reset");
        end_test("reset");

        for (int i = 0; i < 48; i++) begin
            if (i % 8 == 0)
                sound_access(1'b1, 16'hd003, 8'(rand32()));
            a = 16'(rand32());
            if (a[15:14] == 2'b11)
                a[14] = 1'b0;
            sound_access(1'b0, a, 8'h00);
        end
        drain_reads();
        if (dsp_rst !== exp_dsp_rst)
            report_mismatch("dsp_rst", 32'(dsp_rst), 32'(exp_dsp_rst));
        end_test("rom");

        for (int i = 0; i < 16; i++) begin
            addrs[i] = {1'(rand32()) ? 4'hc : 4'hf, 12'(rand32())};
            sound_access(1'b1, addrs[i], 8'(rand32()));
        end
        for (int i = 0; i < 16; i++)
            sound_access(1'b0, addrs[i], 8'h00);
        drain_reads();
        main_buse = 1'b1;
        hold(4);
        if (busrq !== 1'b1)
            report_fault("busrq not raised for main CPU request");
        if (main_grant !== 1'b0)
            report_fault("main_grant rose before busak");
        busak = 1'b1;
        n = 0;
        while (!main_grant && n < 10) begin
            hold(1);
            n++;
        end
        if (!main_grant)
            report_fault("main_grant never rose after busak");
        for (int i = 0; i < 16; i++)
            main_access(1'b0, addrs[i][12:0], 8'h00);
        for (int i = 0; i < 4; i++)
            main_access(1'b1, addrs[i][12:0], 8'(rand32()));
        main_buse = 1'b0;
        hold(1);
        if (main_grant !== 1'b0)
            report_fault("main_grant still high after release");
        busak = 1'b0;
        for (int i = 0; i < 4; i++)
            sound_access(1'b0, addrs[i], 8'h00);
        drain_reads();
        end_test("ram");

        sound_access(1'b0, 16'hd007, 8'h00);
        sound_access(1'b0, 16'hd004, 8'h00);
        sound_access(1'b0, 16'hd006, 8'h00);
        sound_access(1'b0, 16'he123, 8'h00);
        drain_reads();
        end_test("status");

        hi = 8'(rand32());
        lo = 8'(rand32());
        ad = 8'(rand32());
        sound_access(1'b1, 16'hd000, hi);
        sound_access(1'b1, 16'hd001, lo);
        sound_access(1'b1, 16'hd002, ad);
        hold(1);
        if (dsp_irq !== 1'b1)
            report_fault("dsp_irq not raised by mailbox write");
        if (dsp_rdy_n !== 1'b0)
            report_mismatch("dsp_rdy_n", 32'(dsp_rdy_n), 32'(1'b0));
        if (dsp_pbus_in !== {8'h00, ad})
            report_mismatch("dsp_pbus_in", 32'(dsp_pbus_in), 32'({8'h00, ad}));
        sound_access(1'b0, 16'hd007, 8'h00);  // rdy_n low now
        drain_reads();
        dsp_pids = 1'b1;
        hold(1);
        dsp_pids = 1'b0;
        exp_dsp_irq = 1'b0;
        if (dsp_irq !== 1'b0)
            report_fault("dsp_irq not cleared by dsp_pids");
        if (dsp_rdy_n !== 1'b1)
            report_mismatch("dsp_rdy_n", 32'(dsp_rdy_n), 32'(1'b1));
        if (dsp_pbus_in !== {hi, lo})
            report_mismatch("dsp_pbus_in", 32'(dsp_pbus_in), 32'({hi, lo}));
        dsp_iack = 1'b1;
        hold(1);
        if (dsp_rdy_n !== 1'b0)
            report_fault("dsp_rdy_n not low while dsp_iack is high");
        dsp_iack = 1'b0;
        hold(1);
        if (dsp_rdy_n !== 1'b1)
            report_fault("dsp_rdy_n still low after dsp_iack dropped");
        end_test("mailbox");

        for (int f = 0; f < 4; f++) begin
            l = 16'(rand32());
            r = 16'(rand32());
            shift_word(r);  // psel high, right channel
            dsp_psel = 1'b0;
            hold(2);
            shift_word(l);
            dsp_psel = 1'b1;
            n = 0;
            while (!sample && n < 6) begin
                hold(1);
                n++;
            end
            if (!sample)
                report_fault("no sample pulse after psel rise");
            else if (audio !== exp_frame(l, r))
                report_mismatch("audio", audio, exp_frame(l, r));
            hold(1);
            if (sample)
                report_fault("sample pulse longer than one cycle");
        end
        dsp_pbus_out = 16'(rand32());
        dsp_ab = {9'h100, 7'(rand32())};
        dsp_pods_n = 1'b0;
        hold(2);
        dsp_pods_n = 1'b1;
        hold(2);
        dsp_ock = 1'b1;  // ock was left low by the last shift
        hold(2);
        if (qsnd_addr !== {dsp_ab[6:0], dsp_pbus_out})
            report_mismatch("qsnd_addr", 32'(qsnd_addr), 32'({dsp_ab[6:0], dsp_pbus_out}));
        end_test("dsp_out");

        while (!snd_irq)
            hold(1);
        rise1 = cycles;
        int_ack = 1'b1;
        hold(1);
        int_ack = 1'b0;
        if (snd_irq !== 1'b0)
            report_fault("snd_irq not cleared by int_ack");
        while (!snd_irq)
            hold(1);
        rise2 = cycles;
        ticks = (rise2 - rise1) / 2;  // cen8 is every other cycle
        if (ticks < TICK_PERIOD - 1 || ticks > TICK_PERIOD + 1)
            report_mismatch("irq period", 32'(ticks), 32'(TICK_PERIOD));
        end_test("tick_irq");

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors + rsp_errors);
        if (failed == 0 && errors + rsp_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* compile.f */
src/qsnd_bus_pkg.sv
src/qsnd_audio_pkg.sv
src/qsnd_addr_decode.sv
src/qsnd_shared_ram.sv
src/qsnd_tick_irq.sv
src/qsnd_dsp_mailbox.sv
src/qsnd_dsp_out.sv
src/qsnd_sound_top.sv
test/tb_qsnd.sv

/* run.sh */
#!/bin/bash
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_qsnd -o tb_qsnd \
    > sim.log 2>&1 &&
    ./obj_dir/tb_qsnd >> sim.log 2>&1 ||
    echo "TEST RESULT: FAIL" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
